//--- src/alu_pkg.sv
package alu_pkg;

   // width the result struct is built for
   // top level DATA_WIDTH has to agree with it
   localparam int WORD_W = 16;

   // operation held while the unit is busy
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   // control states of the arithmetic unit
   typedef enum logic [3:0] {
      ST_IDLE      = 4'd0,
      // single add through the adder
      ST_ADD       = 4'd1,
      // negate b, then add it to a
      ST_SUB_NEG   = 4'd2,
      ST_SUB_SUM   = 4'd3,
      // second magnitude step for mul and div
      ST_NEG_B     = 4'd4,
      ST_MUL       = 4'd5,
      // restoring division, three states per quotient bit
      ST_DIV_SHIFT = 4'd6,
      ST_DIV_CMP   = 4'd7,
      ST_DIV_CNT   = 4'd8,
      // final two's complement of the magnitude
      ST_SIGN_Q    = 4'd9
   } alu_state_e;

   // result group leaving the arithmetic unit
   typedef struct packed {
      logic signed [WORD_W-1:0] q;
      logic                     ovf;
      // divide by zero only
      logic                     zero;
   } alu_result_t;

endpackage

//--- src/adder.sv
`timescale 1ns/1ps
module adder #(
   parameter int DATA_WIDTH = alu_pkg::WORD_W
) (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf
);

   logic a_top;
   logic b_top;
   logic q_top;

   // wrapped sum, no carry in
   assign o_q   = i_a + i_b;

   assign a_top = i_a[DATA_WIDTH-1];
   assign b_top = i_b[DATA_WIDTH-1];
   assign q_top = o_q[DATA_WIDTH-1];

   // signed overflow
   // operand signs agree but the sum sign flipped
   assign o_ovf = (a_top == b_top) && (q_top != a_top);

endmodule

//--- src/sequential_alu.sv
`timescale 1ns/1ps
module sequential_alu #(
   parameter int DATA_WIDTH = alu_pkg::WORD_W
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   output alu_pkg::alu_result_t         o_res,
   output logic                         o_accept
);

   localparam int                    CNT_W    = $clog2(DATA_WIDTH);
   localparam logic [DATA_WIDTH-1:0] ONE      = {{(DATA_WIDTH-1){1'b0}}, 1'b1};
   localparam logic [DATA_WIDTH-1:0] MIN_PAT  = {1'b1, {(DATA_WIDTH-1){1'b0}}};
   localparam logic [CNT_W-1:0]      CNT_LAST = CNT_W'(DATA_WIDTH-1);

   alu_pkg::alu_state_e          state_r;
   alu_pkg::alu_op_e             op_r;
   alu_pkg::alu_result_t         res_r;
   logic [CNT_W-1:0]             cnt_r;
   logic                         neg_q_r;

   // operand / magnitude registers
   logic [DATA_WIDTH-1:0]        a_r;
   logic [DATA_WIDTH-1:0]        b_r;
   // remainder for div, partial product for mul
   logic [DATA_WIDTH-1:0]        rem_r;

   logic [DATA_WIDTH-1:0]        adder_a;
   logic [DATA_WIDTH-1:0]        adder_b;
   logic signed [DATA_WIDTH-1:0] adder_q;
   logic                         adder_ovf;

   logic                         any_strobe;
   logic                         mag_load;
   logic [DATA_WIDTH-1:0]        sign_src;
   logic [DATA_WIDTH-1:0]        mul_pp_nxt;
   logic                         mul_last;
   logic                         mul_shift_out;
   logic                         mul_over;
   logic                         mul_stop;
   logic                         div_take;
   logic                         div_min_neg1;

   assign any_strobe    = i_add | i_sub | i_mul | i_div;
   // mul/div win arbitration only without add and sub
   assign mag_load      = ~(i_add | i_sub);

   // magnitude to negate at the end
   assign sign_src      = (op_r == alu_pkg::OP_MUL) ? rem_r : a_r;

   // shift-and-add step
   assign mul_pp_nxt    = a_r[0] ? adder_q : rem_r;
   assign mul_last      = (a_r[DATA_WIDTH-1:1] == '0);
   // set multiplicand bit lost while multiplier bits remain
   assign mul_shift_out = b_r[DATA_WIDTH-1] & ~mul_last;
   // sum past the signed range
   // a multiplicand with its top bit set can carry out of the adder
   // exactly 2^(N-1) still fits when the result goes negative
   assign mul_over      = a_r[0] & (adder_ovf | adder_q[DATA_WIDTH-1] | b_r[DATA_WIDTH-1]) &
                          ~(neg_q_r & (adder_q == MIN_PAT));
   assign mul_stop      = mul_shift_out | mul_over;

   // remainder top bit set means it already exceeds any divisor
   assign div_take      = rem_r[DATA_WIDTH-1] | ~adder_q[DATA_WIDTH-1];
   // |a| kept its sign after negation, so a was the minimum
   assign div_min_neg1  = (op_r == alu_pkg::OP_DIV) & a_r[DATA_WIDTH-1] & (b_r == '1);

   // adder input select
   always_comb begin
      adder_a = a_r;
      adder_b = ONE;
      case (state_r)
         // -i_a for the first magnitude
         alu_pkg::ST_IDLE: begin
            adder_a = ~i_a;
         end
         alu_pkg::ST_ADD,
         alu_pkg::ST_SUB_SUM: begin
            adder_a = a_r;
            adder_b = b_r;
         end
         alu_pkg::ST_SUB_NEG,
         alu_pkg::ST_NEG_B: begin
            adder_a = ~b_r;
         end
         // b_r holds -|b| during division
         alu_pkg::ST_MUL,
         alu_pkg::ST_DIV_CMP: begin
            adder_a = rem_r;
            adder_b = b_r;
         end
         alu_pkg::ST_DIV_CNT: begin
            adder_a = {{(DATA_WIDTH-CNT_W){1'b0}}, cnt_r};
         end
         alu_pkg::ST_SIGN_Q: begin
            adder_a = ~sign_src;
         end
         default: begin
            adder_a = a_r;
         end
      endcase
   end

   adder #(
      .DATA_WIDTH (DATA_WIDTH )
   ) adder (
      .i_a        (adder_a    ),
      .i_b        (adder_b    ),
      .o_q        (adder_q    ),
      .o_ovf      (adder_ovf  )
   );

   // control and result
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state_r  <= alu_pkg::ST_IDLE;
         op_r     <= alu_pkg::OP_ADD;
         neg_q_r  <= 1'b0;
         cnt_r    <= '0;
         res_r    <= '0;
         o_accept <= 1'b0;
      end else begin
         o_accept <= 1'b0;
         case (state_r)
            alu_pkg::ST_IDLE: begin
               neg_q_r <= i_a[DATA_WIDTH-1] ^ i_b[DATA_WIDTH-1];
               // fixed priority add, sub, mul, div
               if (i_add) begin
                  op_r    <= alu_pkg::OP_ADD;
                  state_r <= alu_pkg::ST_ADD;
               end else if (i_sub) begin
                  op_r    <= alu_pkg::OP_SUB;
                  state_r <= alu_pkg::ST_SUB_NEG;
               end else if (i_mul) begin
                  op_r    <= alu_pkg::OP_MUL;
                  state_r <= alu_pkg::ST_NEG_B;
               end else if (i_div) begin
                  op_r <= alu_pkg::OP_DIV;
                  // divide by zero finishes right here
                  if (i_b == '0) begin
                     res_r    <= '{q: '0, ovf: 1'b1, zero: 1'b1};
                     o_accept <= 1'b1;
                  end else begin
                     state_r <= alu_pkg::ST_NEG_B;
                  end
               end
            end
            alu_pkg::ST_ADD,
            alu_pkg::ST_SUB_SUM: begin
               res_r    <= '{q: adder_q, ovf: adder_ovf, zero: 1'b0};
               o_accept <= 1'b1;
               state_r  <= alu_pkg::ST_IDLE;
            end
            alu_pkg::ST_SUB_NEG: begin
               // b is the minimum, a - b = a + MIN
               if (adder_ovf) begin
                  res_r    <= '{q: {~a_r[DATA_WIDTH-1], a_r[DATA_WIDTH-2:0]},
                                ovf: ~a_r[DATA_WIDTH-1], zero: 1'b0};
                  o_accept <= 1'b1;
                  state_r  <= alu_pkg::ST_IDLE;
               end else begin
                  state_r <= alu_pkg::ST_SUB_SUM;
               end
            end
            alu_pkg::ST_NEG_B: begin
               if (div_min_neg1) begin
                  res_r    <= '{q: '0, ovf: 1'b1, zero: 1'b0};
                  o_accept <= 1'b1;
                  state_r  <= alu_pkg::ST_IDLE;
               end else if (op_r == alu_pkg::OP_MUL) begin
                  state_r <= alu_pkg::ST_MUL;
               end else begin
                  state_r <= alu_pkg::ST_DIV_SHIFT;
               end
            end
            alu_pkg::ST_MUL: begin
               if (mul_stop) begin
                  res_r    <= '{q: '0, ovf: 1'b1, zero: 1'b0};
                  o_accept <= 1'b1;
                  state_r  <= alu_pkg::ST_IDLE;
               end else if (mul_last) begin
                  if (neg_q_r) begin
                     state_r <= alu_pkg::ST_SIGN_Q;
                  end else begin
                     res_r    <= '{q: mul_pp_nxt, ovf: 1'b0, zero: 1'b0};
                     o_accept <= 1'b1;
                     state_r  <= alu_pkg::ST_IDLE;
                  end
               end
            end
            alu_pkg::ST_DIV_SHIFT: begin
               state_r <= alu_pkg::ST_DIV_CMP;
            end
            alu_pkg::ST_DIV_CMP: begin
               state_r <= alu_pkg::ST_DIV_CNT;
            end
            alu_pkg::ST_DIV_CNT: begin
               if (cnt_r == CNT_LAST) begin
                  cnt_r <= '0;
                  if (neg_q_r) begin
                     state_r <= alu_pkg::ST_SIGN_Q;
                  end else begin
                     res_r    <= '{q: a_r, ovf: 1'b0, zero: 1'b0};
                     o_accept <= 1'b1;
                     state_r  <= alu_pkg::ST_IDLE;
                  end
               end else begin
                  // count through the shared adder
                  cnt_r   <= adder_q[CNT_W-1:0];
                  state_r <= alu_pkg::ST_DIV_SHIFT;
               end
            end
            alu_pkg::ST_SIGN_Q: begin
               // negating MIN_PAT gives MIN_PAT, a valid result
               res_r    <= '{q: adder_q, ovf: 1'b0, zero: 1'b0};
               o_accept <= 1'b1;
               state_r  <= alu_pkg::ST_IDLE;
            end
            default: begin
               state_r <= alu_pkg::ST_IDLE;
            end
         endcase
      end
   end

   // operand and remainder datapath
   always_ff @(posedge i_clk) begin
      case (state_r)
         alu_pkg::ST_IDLE: begin
            // |a| for mul and div, raw a otherwise
            a_r   <= (mag_load && i_a[DATA_WIDTH-1]) ? adder_q : i_a;
            b_r   <= i_b;
            rem_r <= '0;
         end
         alu_pkg::ST_SUB_NEG: begin
            b_r <= adder_q;
         end
         alu_pkg::ST_NEG_B: begin
            // |b| for mul, -|b| for div
            if (b_r[DATA_WIDTH-1] ^ (op_r == alu_pkg::OP_DIV)) begin
               b_r <= adder_q;
            end
         end
         alu_pkg::ST_MUL: begin
            rem_r <= mul_pp_nxt;
            a_r   <= a_r >> 1;
            b_r   <= b_r << 1;
         end
         alu_pkg::ST_DIV_SHIFT: begin
            // next dividend bit into the remainder
            {rem_r, a_r} <= {rem_r[DATA_WIDTH-2:0], a_r, 1'b0};
         end
         alu_pkg::ST_DIV_CMP: begin
            // restore by keeping the old remainder
            if (div_take) begin
               rem_r  <= adder_q;
               a_r[0] <= 1'b1;
            end
         end
         default: begin
            rem_r <= rem_r;
         end
      endcase
   end

   assign o_res = res_r;

   // completion is a single pulse
   a_accept_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_accept |=> !o_accept);

   // no strobe, no new operation
   a_idle_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (state_r == alu_pkg::ST_IDLE) && !any_strobe |=> (state_r == alu_pkg::ST_IDLE));

   // struct field must match the datapath
   a_width: assert property (@(posedge i_clk) DATA_WIDTH == alu_pkg::WORD_W);

endmodule

//--- src/alu_top.sv
`timescale 1ns/1ps
module alu_top #(
   parameter int DATA_WIDTH = alu_pkg::WORD_W
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   // held stable until o_accept
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   // one-cycle request strobes
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_accept
);

   alu_pkg::alu_result_t res;

   sequential_alu #(
      .DATA_WIDTH (DATA_WIDTH )
   ) sequential_alu (
      .i_clk      (i_clk      ),
      .i_nrst     (i_nrst     ),
      .i_a        (i_a        ),
      .i_b        (i_b        ),
      .i_add      (i_add      ),
      .i_sub      (i_sub      ),
      .i_mul      (i_mul      ),
      .i_div      (i_div      ),
      .o_res      (res        ),
      .o_accept   (o_accept   )
   );

   // result struct onto the ports
   assign o_q    = res.q;
   assign o_ovf  = res.ovf;
   // divide by zero flag
   assign o_zero = res.zero;

endmodule

//--- bench/alu_checker.sv
`timescale 1ns/1ps
module alu_checker #(
   parameter int DATA_WIDTH = alu_pkg::WORD_W
) (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   input  logic                         i_add,
   input  logic                         i_sub,
   input  logic                         i_mul,
   input  logic                         i_div,
   input  logic signed [DATA_WIDTH-1:0] i_q,
   input  logic                         i_ovf,
   input  logic                         i_zero,
   input  logic                         i_accept,
   input  logic                         i_done,
   output int                           o_errors,
   output int                           o_ops
);

   // signed range of one word
   localparam longint MAX_V = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
   localparam longint MIN_V = -(longint'(1) <<< (DATA_WIDTH - 1));

   alu_pkg::alu_op_e             exp_op;
   logic signed [DATA_WIDTH-1:0] a_s;
   logic signed [DATA_WIDTH-1:0] b_s;
   logic signed [DATA_WIDTH-1:0] exp_q;
   logic                         exp_ovf;
   logic                         exp_zero;
   // exact latency or upper bound
   int                           exp_lat;
   logic                         lat_exact;
   int                           lat;
   // own view of the unit, idle or busy
   logic                         busy      = 1'b0;
   logic                         late_rep  = 1'b0;
   logic                         reported  = 1'b0;
   // last completed result, must hold
   logic signed [DATA_WIDTH-1:0] held_q    = '0;
   logic                         held_ovf  = 1'b0;
   logic                         held_zero = 1'b0;
   int                           errors    = 0;
   int                           checks    = 0;
   int                           ops       = 0;

   assign o_errors = errors;
   assign o_ops    = ops;

   // reference model in wide integers
   task automatic predict();
      longint t;
      t         = 0;
      exp_q     = '0;
      exp_ovf   = 1'b0;
      exp_zero  = 1'b0;
      lat_exact = 1'b1;
      case (exp_op)
         alu_pkg::OP_ADD: begin
            t       = longint'(a_s) + longint'(b_s);
            exp_q   = t[DATA_WIDTH-1:0];
            exp_ovf = (t > MAX_V) || (t < MIN_V);
            exp_lat = 2;
         end
         alu_pkg::OP_SUB: begin
            t       = longint'(a_s) - longint'(b_s);
            exp_q   = t[DATA_WIDTH-1:0];
            exp_ovf = (t > MAX_V) || (t < MIN_V);
            // negating the minimum ends one step early
            exp_lat = (longint'(b_s) == MIN_V) ? 2 : 3;
         end
         alu_pkg::OP_MUL: begin
            t         = longint'(a_s) * longint'(b_s);
            exp_ovf   = (t > MAX_V) || (t < MIN_V);
            exp_q     = exp_ovf ? '0 : t[DATA_WIDTH-1:0];
            exp_lat   = DATA_WIDTH + 4;
            lat_exact = 1'b0;
         end
         default: begin
            exp_lat   = 3 * DATA_WIDTH + 4;
            lat_exact = 1'b0;
            if (b_s == '0) begin
               // divide by zero finishes at once
               exp_ovf   = 1'b1;
               exp_zero  = 1'b1;
               exp_lat   = 1;
               lat_exact = 1'b1;
            end else if ((longint'(a_s) == MIN_V) && (b_s == '1)) begin
               exp_ovf = 1'b1;
            end else begin
               // longint division truncates toward zero
               t     = longint'(a_s) / longint'(b_s);
               exp_q = t[DATA_WIDTH-1:0];
            end
         end
      endcase
   endtask

   task automatic compare_result();
      checks++;
      if ((i_q !== exp_q) || (i_ovf !== exp_ovf) || (i_zero !== exp_zero)) begin
         errors++;
         $display("ERROR %s a=%0d b=%0d: expected q=%0d ovf=%0b zero=%0b,",
                  exp_op.name(), a_s, b_s, exp_q, exp_ovf, exp_zero,
                  " actual q=%0d ovf=%0b zero=%0b", i_q, i_ovf, i_zero);
      end
      if (lat_exact ? (lat != exp_lat) : (lat > exp_lat)) begin
         errors++;
         $display("ERROR %s latency: expected %s%0d cycles, actual %0d cycles",
                  exp_op.name(), lat_exact ? "" : "at most ", exp_lat, lat);
      end
   endtask

   always @(posedge i_clk) begin
      if (!i_nrst) begin
         busy      = 1'b0;
         held_q    = '0;
         held_ovf  = 1'b0;
         held_zero = 1'b0;
      end else begin
         if (busy) begin
            lat++;
         end
         if (i_accept) begin
            if (!busy) begin
               errors++;
               $display("o_accept pulsed at %0t with no operation pending", $time);
            end else begin
               compare_result();
               ops++;
               busy = 1'b0;
            end
            held_q    = i_q;
            held_ovf  = i_ovf;
            held_zero = i_zero;
         end else if ((i_q !== held_q) || (i_ovf !== held_ovf) || (i_zero !== held_zero)) begin
            errors++;
            $display("ERROR hold: expected q=%0d ovf=%0b zero=%0b, actual q=%0d ovf=%0b zero=%0b",
                     held_q, held_ovf, held_zero, i_q, i_ovf, i_zero);
            // report a change only once
            held_q    = i_q;
            held_ovf  = i_ovf;
            held_zero = i_zero;
         end
         if (busy && !late_rep && (lat > exp_lat)) begin
            errors++;
            late_rep = 1'b1;
            $display("%s of a=%0d b=%0d gave no o_accept within %0d cycles",
                     exp_op.name(), a_s, b_s, exp_lat);
         end
         // strobes only count in idle, add first, div last
         if (!busy && (i_add || i_sub || i_mul || i_div)) begin
            if (i_add) begin
               exp_op = alu_pkg::OP_ADD;
            end else if (i_sub) begin
               exp_op = alu_pkg::OP_SUB;
            end else if (i_mul) begin
               exp_op = alu_pkg::OP_MUL;
            end else begin
               exp_op = alu_pkg::OP_DIV;
            end
            a_s      = i_a;
            b_s      = i_b;
            predict();
            busy     = 1'b1;
            lat      = 0;
            late_rep = 1'b0;
         end
         if (i_done && !reported) begin
            reported = 1'b1;
            $display("checker: %0d operations, %0d result checks, %0d errors",
                     ops, checks, errors);
         end
      end
   end

endmodule

//--- bench/tb_alu.sv
`timescale 1ns/1ps
module tb_alu;

   localparam int DATA_WIDTH = alu_pkg::WORD_W;
   localparam int N_OPS      = 200;
   // slowest op is a divide, plus idle gaps
   localparam int MAX_CYCLES = N_OPS * (3 * DATA_WIDTH + 8) + 100;
   localparam int HALF       = DATA_WIDTH / 2;

   logic                         clk;
   logic                         nrst;
   logic signed [DATA_WIDTH-1:0] op_a;
   logic signed [DATA_WIDTH-1:0] op_b;
   logic                         do_add;
   logic                         do_sub;
   logic                         do_mul;
   logic                         do_div;
   logic signed [DATA_WIDTH-1:0] q;
   logic                         ovf;
   logic                         zero;
   logic                         accept;
   logic                         done;
   int                           seed;
   int                           cycles = 0;
   int                           idle;
   int                           r;
   int                           chk_errors;
   int                           chk_ops;

   alu_top #(
      .DATA_WIDTH (DATA_WIDTH )
   ) i_alu_top (
      .i_clk      (clk        ),
      .i_nrst     (nrst       ),
      .i_a        (op_a       ),
      .i_b        (op_b       ),
      .i_add      (do_add     ),
      .i_sub      (do_sub     ),
      .i_mul      (do_mul     ),
      .i_div      (do_div     ),
      .o_q        (q          ),
      .o_ovf      (ovf        ),
      .o_zero     (zero       ),
      .o_accept   (accept     )
   );

   // watches every DUT port
   alu_checker #(
      .DATA_WIDTH (DATA_WIDTH )
   ) i_alu_checker (
      .i_clk      (clk        ),
      .i_nrst     (nrst       ),
      .i_a        (op_a       ),
      .i_b        (op_b       ),
      .i_add      (do_add     ),
      .i_sub      (do_sub     ),
      .i_mul      (do_mul     ),
      .i_div      (do_div     ),
      .i_q        (q          ),
      .i_ovf      (ovf        ),
      .i_zero     (zero       ),
      .i_accept   (accept     ),
      .i_done     (done       ),
      .o_errors   (chk_errors ),
      .o_ops      (chk_ops    )
   );

   // 4 ns period
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout: run not finished after %0d cycles, %0d errors so far",
                  MAX_CYCLES, chk_errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic set_strobes(input logic [3:0] mask);
      {do_add, do_sub, do_mul, do_div} = mask;
   endtask

   // quarter corners, quarter small, rest full range
   function automatic logic signed [DATA_WIDTH-1:0] pick_operand();
      int sel;
      int val;
      sel = $random(seed);
      val = $random(seed);
      if ((sel & 3) == 0) begin
         case ($unsigned(val) % 5)
            0: return '0;
            1: return {{(DATA_WIDTH-1){1'b0}}, 1'b1};
            2: return '1;
            3: return {1'b1, {(DATA_WIDTH-1){1'b0}}};
            default: return {1'b0, {(DATA_WIDTH-1){1'b1}}};
         endcase
      end else if ((sel & 3) == 1) begin
         // small values keep many products in range
         return {{(DATA_WIDTH-HALF){val[HALF-1]}}, val[HALF-1:0]};
      end
      return val[DATA_WIDTH-1:0];
   endfunction

   // mostly one strobe, sometimes several at once
   function automatic logic [3:0] pick_strobes();
      int v;
      v = $random(seed);
      if ((v & 3) == 0) begin
         return (v[7:4] == 4'd0) ? 4'b0001 : v[7:4];
      end
      return 4'b0001 << v[9:8];
   endfunction

   initial begin
      seed = 37;
      nrst = 1'b0;
      op_a = '0;
      op_b = '0;
      done = 1'b0;
      set_strobes(4'b0000);
      repeat (3) @(posedge clk);
      @(negedge clk);
      nrst = 1'b1;
      // one quiet cycle to see reset values
      @(negedge clk);
      for (int n = 0; n < N_OPS; n++) begin
         op_a = pick_operand();
         op_b = pick_operand();
         set_strobes(pick_strobes());
         @(negedge clk);
         // operands held, stray strobes while busy
         while (!accept) begin
            r = $random(seed);
            if ((r & 7) == 0) begin
               set_strobes(r[11:8]);
            end else begin
               set_strobes(4'b0000);
            end
            @(negedge clk);
         end
         set_strobes(4'b0000);
         r = $random(seed);
         idle = r & 3;
         repeat (idle) @(negedge clk);
      end
      done = 1'b1;
      @(negedge clk);
      @(negedge clk);
      if ((chk_errors == 0) && (chk_ops == N_OPS)) begin
         $display("=== PASS ===");
      end else begin
         if (chk_ops != N_OPS) begin
            $display("only %0d of %0d operations completed", chk_ops, N_OPS);
         end
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

//--- compile.f
src/alu_pkg.sv
src/adder.sv
src/sequential_alu.sv
src/alu_top.sv
bench/alu_checker.sv
bench/tb_alu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ALU testbench with Verilator
LOG=sim.log
rm -f "$LOG" build.log
verilator --binary --timing --assert -j 0 --top-module tb_alu -Mdir obj_dir \
   -f compile.f > build.log 2>&1 \
   && ./obj_dir/Vtb_alu > "$LOG" 2>&1 \
   || { cat build.log "$LOG" 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat "$LOG"
# verdict comes from the log
grep -q "=== FAIL ===" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" "$LOG" || { echo "no verdict in $LOG"; exit 1; }
echo "simulation passed"
